// ==== Makefile ====
# Verilator flow for the ID tracker front end

TOP = tb_id_tracker

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "RESULT: FAIL" sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held for 16 rising edges
    initial begin
        rst_o = 1'b1;
        repeat (16) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== bench/tb_id_tracker.sv ====
module tb_id_tracker;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TEST_CYCLES = 1200;
    localparam logic [31:0] SEED = 32'hde39574f;

    logic clk;
    logic rst;
    logic flush_i;
    logic [31:0] pc_i;
    logic pc_id_assigned_i;
    id_pkg::id_t pc_id_o;
    logic pc_id_available_o;
    id_pkg::fetch_return_t fetch_ret_i;
    id_pkg::id_t fetch_id_o;
    id_pkg::decode_packet_t decode_o;
    logic decode_advance_i;
    logic retire_i;
    id_pkg::id_t retire_id_i;
    logic cfg_req_i;
    id_pkg::cfg_req_t cfg_i;
    logic cfg_ack_o;
    logic [31:0] cfg_rdata_o;

    // Reference model state
    id_pkg::id_t m_pc_id;
    id_pkg::id_t m_fetch_id;
    id_pkg::id_t pend[$];
    id_pkg::id_t fq[$];
    id_pkg::id_t dec[$];
    logic [31:0] pc_tab [id_pkg::NUM_IDS];
    logic [31:0] ins_tab [id_pkg::NUM_IDS];
    logic [id_pkg::NUM_IDS-1:0] busy;
    int m_retired;
    int cur_limit;
    int errors;
    bit checking;
    logic [31:0] lfsr_state;

    // Outputs sampled mid-cycle
    logic s_avail;
    logic s_dec_valid;

    tb_clock_gen i_tb_clock_gen (.clk_o(clk), .rst_o(rst));

    id_tracker_top i_id_tracker_top (
        .clk(clk), .rst(rst), .flush_i(flush_i),
        .pc_i(pc_i), .pc_id_assigned_i(pc_id_assigned_i),
        .pc_id_o(pc_id_o), .pc_id_available_o(pc_id_available_o),
        .fetch_ret_i(fetch_ret_i), .fetch_id_o(fetch_id_o),
        .decode_o(decode_o), .decode_advance_i(decode_advance_i),
        .retire_i(retire_i), .retire_id_i(retire_id_i),
        .cfg_req_i(cfg_req_i), .cfg_i(cfg_i),
        .cfg_ack_o(cfg_ack_o), .cfg_rdata_o(cfg_rdata_o)
    );

    ////////////////////////////////////////////////////////////
    // Random source and reference functions

    // Galois form with taps x^32 x^22 x^2 x^1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Head of the queue waits on a full window
    function automatic bit expect_decode_valid(input int queued, input int inflight,
                                               input int limit);
        return queued > 0 && inflight < limit;
    endfunction

    // Rewind to the oldest undecoded ID or leave the counter where it is
    function automatic id_pkg::id_t expect_rewind(input bit queued, input id_pkg::id_t head,
                                                  input id_pkg::id_t pc_id);
        return queued ? head : pc_id;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "Run aborted");
    endtask

    ////////////////////////////////////////////////////////////
    // Model update for the events of the cycle that just ended

    task automatic update_model();
        int idx;
        id_pkg::id_t id;
        if (flush_i) begin
            id = expect_rewind(fq.size() > 0, (fq.size() > 0) ? fq[0] : '0, m_pc_id);
            m_pc_id = id;
            m_fetch_id = id;
            foreach (pend[i]) busy[pend[i]] = 1'b0;
            foreach (fq[i]) busy[fq[i]] = 1'b0;
            pend.delete();
            fq.delete();
        end else begin
            if (pc_id_assigned_i) begin
                pc_tab[m_pc_id] = pc_i;
                busy[m_pc_id] = 1'b1;
                pend.push_back(m_pc_id);
                m_pc_id = m_pc_id + 1'b1;
            end
            if (fetch_ret_i.valid) begin
                id = pend.pop_front();
                ins_tab[id] = fetch_ret_i.instruction;
                fq.push_back(id);
                m_fetch_id = m_fetch_id + 1'b1;
            end
            if (decode_advance_i) begin
                dec.push_back(fq.pop_front());
            end
        end
        if (retire_i) begin
            idx = -1;
            foreach (dec[i]) if (dec[i] == retire_id_i) idx = i;
            if (idx < 0) stop_run("Retire of an ID that was not decoded");
            dec.delete(idx);
            busy[retire_id_i] = 1'b0;
            m_retired++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One cycle of random traffic

    // Events only follow a quiet cycle so the sampled flags still hold
    task automatic step_cycle(input bit asg_en, input bit flush_en, input int ret_sh,
                              input bit move_en);
        bit fl;
        bit asg;
        bit ret;
        bit adv;
        bit rt;
        int pick;
        @(posedge clk);
        update_model();
        fl = flush_en && !flush_i && take_bits(4) == 0;
        asg = 1'b0;
        ret = 1'b0;
        adv = 1'b0;
        if (!fl) begin
            asg = asg_en && s_avail && !pc_id_assigned_i && !flush_i && take_bits(1) == 1;
            ret = move_en && pend.size() > 0 && take_bits(1) == 1;
            adv = move_en && s_dec_valid && fq.size() > 0 && !decode_advance_i && !flush_i
                && take_bits(1) == 1;
        end
        rt = ret_sh > 0 && dec.size() > 0 && take_bits(ret_sh) == 0;
        pick = rt ? int'(take_bits(8)) % dec.size() : 0;
        flush_i <= fl;
        pc_id_assigned_i <= asg;
        pc_i <= asg ? take_bits(32) : '0;
        fetch_ret_i.valid <= ret;
        fetch_ret_i.instruction <= ret ? take_bits(32) : '0;
        decode_advance_i <= adv;
        retire_i <= rt;
        retire_id_i <= rt ? dec[pick] : '0;
    endtask

    task automatic drain_all();
        int n;
        n = 0;
        while (pend.size() + fq.size() + dec.size() > 0) begin
            if (n >= 150) stop_run("Drain did not empty the ID ring");
            step_cycle(1'b0, 1'b0, 1, 1'b1);
            n++;
        end
        repeat (2) step_cycle(1'b0, 1'b0, 0, 1'b0);
        // Whole ring free once the last retire has settled
        @(negedge clk);
        check("drain_avail", 32'd1, 32'(pc_id_available_o));
    endtask

    // Four-phase access with ack one cycle after req and drop one cycle after req drop
    task automatic cfg_access(input string name, input bit wr, input logic [1:0] addr,
                              input logic [31:0] wdata, input logic [31:0] exp);
        @(posedge clk);
        cfg_req_i <= 1'b1;
        cfg_i.write <= wr;
        cfg_i.addr <= addr;
        cfg_i.wdata <= wdata;
        @(negedge clk);
        check({name, "_ack_early"}, 32'd0, 32'(cfg_ack_o));
        @(negedge clk);
        check({name, "_ack"}, 32'd1, 32'(cfg_ack_o));
        if (!wr) check(name, exp, cfg_rdata_o);
        @(posedge clk);
        cfg_req_i <= 1'b0;
        @(negedge clk);
        check({name, "_ack_hold"}, 32'd1, 32'(cfg_ack_o));
        @(negedge clk);
        check({name, "_ack_drop"}, 32'd0, 32'(cfg_ack_o));
    endtask

    ////////////////////////////////////////////////////////////
    // Compare process

    always @(negedge clk) begin
        s_avail = pc_id_available_o;
        s_dec_valid = decode_o.valid;
        if (checking) begin
            check("pc_id", 32'(m_pc_id), 32'(pc_id_o));
            check("fetch_id", 32'(m_fetch_id), 32'(fetch_id_o));
            check("avail_busy_id", 32'd0, 32'(s_avail && busy[m_pc_id]));
            check("decode_valid", 32'(expect_decode_valid(fq.size(), dec.size(), cur_limit)),
                  32'(decode_o.valid));
            if (fq.size() > 0) begin
                check("decode_id", 32'(fq[0]), 32'(decode_o.id));
                check("decode_pc", pc_tab[fq[0]], decode_o.pc);
                check("decode_instr", ins_tab[fq[0]], decode_o.instruction);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Watchdog

    initial begin
        #(TEST_CYCLES * 4 * 8);
        stop_run("Timeout, the test did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        flush_i = 1'b0;
        pc_i = '0;
        pc_id_assigned_i = 1'b0;
        fetch_ret_i = '0;
        decode_advance_i = 1'b0;
        retire_i = 1'b0;
        retire_id_i = '0;
        cfg_req_i = 1'b0;
        cfg_i = '0;
        m_pc_id = '0;
        m_fetch_id = '0;
        busy = '0;
        m_retired = 0;
        cur_limit = int'(id_pkg::WINDOW_RESET);
        errors = 0;
        checking = 1'b0;
        lfsr_state = SEED;

        @(negedge clk);
        while (rst) @(negedge clk);
        checking = 1'b1;
        check("reset_avail", 32'd1, 32'(pc_id_available_o));
        check("reset_ack", 32'd0, 32'(cfg_ack_o));
        cfg_access("reset_limit", 1'b0, id_pkg::CFG_ADDR_LIMIT, '0, 32'(id_pkg::NUM_IDS));
        cfg_access("reset_inflight", 1'b0, id_pkg::CFG_ADDR_INFLIGHT, '0, 32'd0);
        cfg_access("reset_retired", 1'b0, id_pkg::CFG_ADDR_RETIRED, '0, 32'd0);

        // Full window with flushes
        repeat (450) step_cycle(1'b1, 1'b1, 1, 1'b1);
        repeat (3) step_cycle(1'b0, 1'b0, 0, 1'b0);
        cfg_access("inflight_a", 1'b0, id_pkg::CFG_ADDR_INFLIGHT, '0, 32'(dec.size()));
        cfg_access("retired_a", 1'b0, id_pkg::CFG_ADDR_RETIRED, '0, 32'(m_retired));
        drain_all();

        // Narrow window, slow retire builds back-pressure
        cfg_access("limit_wr", 1'b1, id_pkg::CFG_ADDR_LIMIT, 32'd2, '0);
        cur_limit = 2;
        cfg_access("limit_rd", 1'b0, id_pkg::CFG_ADDR_LIMIT, '0, 32'd2);
        repeat (350) step_cycle(1'b1, 1'b0, 3, 1'b1);
        repeat (3) step_cycle(1'b0, 1'b0, 0, 1'b0);
        cfg_access("inflight_b", 1'b0, id_pkg::CFG_ADDR_INFLIGHT, '0, 32'(dec.size()));
        drain_all();

        // Read-only register ignores writes
        cfg_access("retired_wr", 1'b1, id_pkg::CFG_ADDR_RETIRED, 32'h55, '0);
        cfg_access("retired_b", 1'b0, id_pkg::CFG_ADDR_RETIRED, '0, 32'(m_retired));
        cfg_access("limit_restore", 1'b1, id_pkg::CFG_ADDR_LIMIT, 32'(id_pkg::NUM_IDS), '0);
        cur_limit = id_pkg::NUM_IDS;
        cfg_access("limit_final", 1'b0, id_pkg::CFG_ADDR_LIMIT, '0, 32'(id_pkg::NUM_IDS));

        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "Checks failed");
        end
    end

endmodule

// ==== common/id_pkg.sv ====
package id_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    // IDs in the ring, one word of toggle bits
    localparam int NUM_IDS = 8;
    localparam int ID_W = 3;

    // In-flight count and window limit must reach NUM_IDS
    localparam int CNT_W = ID_W + 1;
    localparam int RETIRED_W = 16;

    typedef logic [ID_W-1:0] id_t;
    typedef logic [CNT_W-1:0] cnt_t;

    ////////////////////////////////////////////////////////////
    // Configuration map

    localparam int CFG_ADDR_W = 2;

    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_LIMIT = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_INFLIGHT = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_RETIRED = 2'd2;

    // Full window out of reset
    localparam cnt_t WINDOW_RESET = cnt_t'(NUM_IDS);

    ////////////////////////////////////////////////////////////
    // Bundles

    typedef struct packed {
        logic valid;
        id_t id;
        logic [31:0] pc;
        logic [31:0] instruction;
    } decode_packet_t;

    // ID of a return is whatever the fetch counter shows
    typedef struct packed {
        logic valid;
        logic [31:0] instruction;
    } fetch_return_t;

    typedef struct packed {
        logic write;
        logic [CFG_ADDR_W-1:0] addr;
        logic [31:0] wdata;
    } cfg_req_t;

endpackage

// ==== compile.f ====
common/id_pkg.sv
verilog/toggle_memory.sv
verilog/id_fifo.sv
id_manager/id_allocator.sv
id_manager/metadata_tables.sv
verilog/window_config.sv
verilog/id_tracker_top.sv
bench/tb_clock_gen.sv
bench/tb_id_tracker.sv

// ==== id_manager/id_allocator.sv ====
module id_allocator (
    input logic clk,
    input logic rst,

    input logic flush_i,

    // Fetch side
    input logic pc_id_assigned_i,
    input logic fetch_ret_valid_i,

    // Decode and retire events
    input logic decode_advance_i,
    input logic retire_i,
    input id_pkg::id_t retire_id_i,

    input id_pkg::cnt_t window_limit_i,

    output id_pkg::id_t pc_id_o,
    output logic pc_id_available_o,
    output id_pkg::id_t fetch_id_o,
    output id_pkg::id_t decode_id_o,
    output logic decode_valid_o,
    output id_pkg::cnt_t inflight_count_o
);

    id_pkg::id_t pc_id_q;
    id_pkg::id_t pc_id_next;
    id_pkg::id_t fetch_id_q;
    id_pkg::id_t rewind_id;

    // FIFO head
    id_pkg::id_t fifo_head;
    logic fifo_valid;

    logic decode_pop;
    logic fetch_push;

    // Assigned but not yet decoded
    id_pkg::cnt_t pre_decode_q;
    id_pkg::cnt_t pre_decode_next;
    // Decoded but not yet retired
    id_pkg::cnt_t inflight_q;

    logic decoded_bit;
    logic retired_bit;
    logic next_id_free;

    // Flush wins over decode and return in the same cycle
    assign decode_pop = decode_advance_i & ~flush_i;
    assign fetch_push = fetch_ret_valid_i & ~flush_i;

    ////////////////////////////////////////////////////////////
    // ID counters

    // Oldest undecoded ID, or nothing dropped when queue empty
    assign rewind_id = fifo_valid ? fifo_head : pc_id_q;
    assign pc_id_next = flush_i ? rewind_id : pc_id_q + id_pkg::id_t'(pc_id_assigned_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_id_q <= '0;
        end else begin
            pc_id_q <= pc_id_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_id_q <= '0;
        end else if (flush_i) begin
            fetch_id_q <= rewind_id;
        end else begin
            fetch_id_q <= fetch_id_q + id_pkg::id_t'(fetch_ret_valid_i);
        end
    end

    ////////////////////////////////////////////////////////////
    // Fetched ID queue

    id_fifo i_fetch_fifo (
        .clk(clk),
        .rst(rst),
        .clear_i(flush_i),
        .push_i(fetch_push),
        .data_i(fetch_id_q),
        .pop_i(decode_pop),
        .data_o(fifo_head),
        .valid_o(fifo_valid)
    );

    ////////////////////////////////////////////////////////////
    // Free-ID tracking

    // Bits differ while an ID sits between decode and retire
    toggle_memory i_decode_toggle (
        .clk(clk),
        .rst(rst),
        .toggle_i(decode_pop),
        .toggle_id_i(fifo_head),
        .read_id_i(pc_id_next),
        .read_o(decoded_bit)
    );

    toggle_memory i_retire_toggle (
        .clk(clk),
        .rst(rst),
        .toggle_i(retire_i),
        .toggle_id_i(retire_id_i),
        .read_id_i(pc_id_next),
        .read_o(retired_bit)
    );

    // Undecoded IDs have equal bits, so a full ring wrap is caught by count
    assign pre_decode_next = flush_i ? '0
        : pre_decode_q + id_pkg::cnt_t'(pc_id_assigned_i) - id_pkg::cnt_t'(decode_pop);

    // Head being decoded now still reads as free
    assign next_id_free = (decoded_bit == retired_bit)
        && !(decode_pop && fifo_head == pc_id_next)
        && pre_decode_next != id_pkg::cnt_t'(id_pkg::NUM_IDS);

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_decode_q <= '0;
            pc_id_available_o <= 1'b1;
        end else begin
            pre_decode_q <= pre_decode_next;
            pc_id_available_o <= next_id_free;
        end
    end

    ////////////////////////////////////////////////////////////
    // Window

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_q <= '0;
        end else begin
            inflight_q <= inflight_q + id_pkg::cnt_t'(decode_pop) - id_pkg::cnt_t'(retire_i);
        end
    end

    // Full window holds the ID in the queue
    assign decode_valid_o = fifo_valid && (inflight_q < window_limit_i);

    assign pc_id_o = pc_id_q;
    assign fetch_id_o = fetch_id_q;
    assign decode_id_o = fifo_head;
    assign inflight_count_o = inflight_q;

    ////////////////////////////////////////////////////////////
    // Checks

    assign_without_id: assert property (
        @(posedge clk) disable iff (rst) pc_id_assigned_i |-> pc_id_available_o
    ) else $error("PC ID assigned while none available");

    advance_without_valid: assert property (
        @(posedge clk) disable iff (rst) decode_advance_i |-> decode_valid_o
    ) else $error("Decode advanced without a valid ID");

endmodule

// ==== id_manager/metadata_tables.sv ====
module metadata_tables (
    input logic clk,

    // PC write at assignment
    input logic pc_we_i,
    input id_pkg::id_t pc_id_i,
    input logic [31:0] pc_i,

    // Instruction write at fetch return
    input logic instr_we_i,
    input id_pkg::id_t fetch_id_i,
    input logic [31:0] instruction_i,

    // Head of the fetched queue
    input id_pkg::id_t decode_id_i,
    input logic decode_valid_i,
    output id_pkg::decode_packet_t decode_o
);

    // Per-ID payload, written once per use of an ID
    logic [31:0] pc_table [id_pkg::NUM_IDS];
    logic [31:0] instr_table [id_pkg::NUM_IDS];

    ////////////////////////////////////////////////////////////
    // PC table

    always_ff @(posedge clk) begin
        if (pc_we_i) begin
            pc_table[pc_id_i] <= pc_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction table

    // A return that races a flush lands here too, the ID is reused later
    always_ff @(posedge clk) begin
        if (instr_we_i) begin
            instr_table[fetch_id_i] <= instruction_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode read-out

    // Both words are in place by the time the ID leaves the queue
    always_comb begin
        decode_o.valid = decode_valid_i;
        decode_o.id = decode_id_i;
        decode_o.pc = pc_table[decode_id_i];
        decode_o.instruction = instr_table[decode_id_i];
    end

endmodule

// ==== verilog/id_fifo.sv ====
module id_fifo (
    input logic clk,
    input logic rst,

    // Drops every queued entry
    input logic clear_i,

    input logic push_i,
    input id_pkg::id_t data_i,

    input logic pop_i,
    output id_pkg::id_t data_o,
    output logic valid_o
);

    // Storage, one slot per ID so it never really fills
    id_pkg::id_t mem [id_pkg::NUM_IDS];

    // Pointers wrap on their own, NUM_IDS is a power of two
    id_pkg::id_t wr_ptr;
    id_pkg::id_t rd_ptr;
    id_pkg::cnt_t count;

    logic full;

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + id_pkg::id_t'(push_i);
            rd_ptr <= rd_ptr + id_pkg::id_t'(pop_i);
            // Push and pop together leave count as is
            count <= count + id_pkg::cnt_t'(push_i) - id_pkg::cnt_t'(pop_i);
        end
    end

    assign full = count == id_pkg::cnt_t'(id_pkg::NUM_IDS);

    // Head entry, registered path only
    assign valid_o = count != '0;
    assign data_o = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Checks

    pop_while_empty: assert property (
        @(posedge clk) disable iff (rst) pop_i |-> valid_o
    ) else $error("FIFO pop while empty");

    // Simultaneous pop frees a slot
    push_while_full: assert property (
        @(posedge clk) disable iff (rst) push_i |-> (!full || pop_i)
    ) else $error("FIFO push while full");

endmodule

// ==== verilog/id_tracker_top.sv ====
module id_tracker_top (
    input logic clk,
    input logic rst,

    input logic flush_i,

    // PC issue
    input logic [31:0] pc_i,
    input logic pc_id_assigned_i,
    output id_pkg::id_t pc_id_o,
    output logic pc_id_available_o,

    // Instruction return
    input id_pkg::fetch_return_t fetch_ret_i,
    output id_pkg::id_t fetch_id_o,

    // Decode
    output id_pkg::decode_packet_t decode_o,
    input logic decode_advance_i,

    // Retire
    input logic retire_i,
    input id_pkg::id_t retire_id_i,

    // Configuration port
    input logic cfg_req_i,
    input id_pkg::cfg_req_t cfg_i,
    output logic cfg_ack_o,
    output logic [31:0] cfg_rdata_o
);

    id_pkg::cnt_t window_limit;
    id_pkg::cnt_t inflight_count;
    id_pkg::id_t decode_id;
    logic decode_valid;

    ////////////////////////////////////////////////////////////
    // ID ring, queue and window

    id_allocator i_id_allocator (
        .clk(clk),
        .rst(rst),
        .flush_i(flush_i),
        .pc_id_assigned_i(pc_id_assigned_i),
        .fetch_ret_valid_i(fetch_ret_i.valid),
        .decode_advance_i(decode_advance_i),
        .retire_i(retire_i),
        .retire_id_i(retire_id_i),
        .window_limit_i(window_limit),
        .pc_id_o(pc_id_o),
        .pc_id_available_o(pc_id_available_o),
        .fetch_id_o(fetch_id_o),
        .decode_id_o(decode_id),
        .decode_valid_o(decode_valid),
        .inflight_count_o(inflight_count)
    );

    // PC and instruction words per ID
    metadata_tables i_metadata_tables (
        .clk(clk),
        .pc_we_i(pc_id_assigned_i),
        .pc_id_i(pc_id_o),
        .pc_i(pc_i),
        .instr_we_i(fetch_ret_i.valid),
        .fetch_id_i(fetch_id_o),
        .instruction_i(fetch_ret_i.instruction),
        .decode_id_i(decode_id),
        .decode_valid_i(decode_valid),
        .decode_o(decode_o)
    );

    // Limit register and status counters
    window_config i_window_config (
        .clk(clk),
        .rst(rst),
        .cfg_req_i(cfg_req_i),
        .cfg_i(cfg_i),
        .cfg_ack_o(cfg_ack_o),
        .cfg_rdata_o(cfg_rdata_o),
        .inflight_count_i(inflight_count),
        .retire_i(retire_i),
        .window_limit_o(window_limit)
    );

endmodule

// ==== verilog/toggle_memory.sv ====
module toggle_memory (
    input logic clk,
    input logic rst,

    // Event side
    input logic toggle_i,
    input id_pkg::id_t toggle_id_i,

    // Status lookup
    input id_pkg::id_t read_id_i,
    output logic read_o
);

    // One bit per ID
    logic [id_pkg::NUM_IDS-1:0] bits;

    ////////////////////////////////////////////////////////////
    // Flip on event

    // Every ID starts with an even event count
    always_ff @(posedge clk) begin
        if (rst) begin
            bits <= '0;
        end else if (toggle_i) begin
            bits[toggle_id_i] <= ~bits[toggle_id_i];
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port

    // Combinational, so a flip in this cycle is not yet seen
    assign read_o = bits[read_id_i];

endmodule

// ==== verilog/window_config.sv ====
module window_config (
    input logic clk,
    input logic rst,

    // Four-phase slave
    input logic cfg_req_i,
    input id_pkg::cfg_req_t cfg_i,
    output logic cfg_ack_o,
    output logic [31:0] cfg_rdata_o,

    // Status inputs
    input id_pkg::cnt_t inflight_count_i,
    input logic retire_i,

    output id_pkg::cnt_t window_limit_o
);

    // Ack state also waits for req low
    typedef enum logic {
        CFG_IDLE,
        CFG_ACK
    } cfg_state_t;

    cfg_state_t state;
    logic access;
    logic [31:0] read_value;

    id_pkg::cnt_t limit_q;
    logic [id_pkg::RETIRED_W-1:0] retired_q;

    // New request seen only from idle
    assign access = (state == CFG_IDLE) && cfg_req_i;

    ////////////////////////////////////////////////////////////
    // Handshake and registers

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CFG_IDLE;
            limit_q <= id_pkg::WINDOW_RESET;
        end else begin
            case (state)
                CFG_IDLE: if (cfg_req_i) state <= CFG_ACK;
                CFG_ACK: if (!cfg_req_i) state <= CFG_IDLE;
                default: state <= CFG_IDLE;
            endcase
            // Only the limit is writable
            if (access && cfg_i.write && cfg_i.addr == id_pkg::CFG_ADDR_LIMIT) begin
                limit_q <= cfg_i.wdata[id_pkg::CNT_W-1:0];
            end
        end
    end

    // Total retire pulses, wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            retired_q <= '0;
        end else if (retire_i) begin
            retired_q <= retired_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data

    always_comb begin
        case (cfg_i.addr)
            id_pkg::CFG_ADDR_LIMIT: read_value = 32'(limit_q);
            id_pkg::CFG_ADDR_INFLIGHT: read_value = 32'(inflight_count_i);
            id_pkg::CFG_ADDR_RETIRED: read_value = 32'(retired_q);
            default: read_value = '0;
        endcase
    end

    // Snapshot at access, held through ack
    always_ff @(posedge clk) begin
        if (access) begin
            cfg_rdata_o <= read_value;
        end
    end

    assign cfg_ack_o = (state == CFG_ACK);
    assign window_limit_o = limit_q;

    ////////////////////////////////////////////////////////////
    // Checks

    req_held_stable: assert property (
        @(posedge clk) disable iff (rst) (cfg_req_i && !cfg_ack_o) |=> $stable(cfg_i)
    ) else $error("Configuration request changed before ack");

    limit_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (access && cfg_i.write && cfg_i.addr == id_pkg::CFG_ADDR_LIMIT)
        |-> (cfg_i.wdata >= 32'd1 && cfg_i.wdata <= 32'(id_pkg::NUM_IDS))
    ) else $error("Window limit out of range");

endmodule
